/* uop_pkg.sv */
// ========================================
// shared constants and types of the micro-op cluster
// opcode values are local to this cluster and carry no 6502 meaning
// the D flag is stored by the ALU but decimal arithmetic is not done
// ========================================

package uop_pkg;

	// ========================================
	// widths
	// ========================================

	// one micro-op word as the sequencer presents it
	localparam int UOP_W  = 20;
	// internal datapath, wider than the 8-bit architectural byte
	localparam int DATA_W = 16;
	localparam int NREG   = 8;
	// register index width follows the register count
	localparam int REG_AW = $clog2(NREG);
	localparam int OP_W   = 6;

	// ========================================
	// opcodes
	// ========================================

	// everything not listed here is treated as an unknown opcode
	localparam logic [OP_W-1:0] UO_LDIB = 6'h01;
	localparam logic [OP_W-1:0] UO_ADDW = 6'h02;
	localparam logic [OP_W-1:0] UO_ADDB = 6'h03;
	localparam logic [OP_W-1:0] UO_ADCB = 6'h04;
	localparam logic [OP_W-1:0] UO_SBCB = 6'h05;
	localparam logic [OP_W-1:0] UO_CMPB = 6'h06;
	localparam logic [OP_W-1:0] UO_ANDB = 6'h07;
	localparam logic [OP_W-1:0] UO_BITB = 6'h08;
	localparam logic [OP_W-1:0] UO_ORB  = 6'h09;
	localparam logic [OP_W-1:0] UO_EORB = 6'h0a;
	localparam logic [OP_W-1:0] UO_MOV  = 6'h0b;
	localparam logic [OP_W-1:0] UO_ASLB = 6'h0c;
	localparam logic [OP_W-1:0] UO_LSRB = 6'h0d;
	localparam logic [OP_W-1:0] UO_ROLB = 6'h0e;
	localparam logic [OP_W-1:0] UO_RORB = 6'h0f;
	// flag micro-ops only touch the status byte
	localparam logic [OP_W-1:0] UO_CLC  = 6'h10;
	localparam logic [OP_W-1:0] UO_SEC  = 6'h11;
	localparam logic [OP_W-1:0] UO_CLV  = 6'h12;
	localparam logic [OP_W-1:0] UO_SEI  = 6'h13;
	localparam logic [OP_W-1:0] UO_CLI  = 6'h14;
	localparam logic [OP_W-1:0] UO_SED  = 6'h15;
	localparam logic [OP_W-1:0] UO_CLD  = 6'h16;
	localparam logic [OP_W-1:0] UO_SEB  = 6'h17;
	localparam logic [OP_W-1:0] UO_CLB  = 6'h18;

	// status byte bit positions, bit 5 is unused as on the 6502
	localparam int ST_C = 0;
	localparam int ST_Z = 1;
	localparam int ST_I = 2;
	localparam int ST_D = 3;
	localparam int ST_B = 4;
	localparam int ST_V = 6;
	localparam int ST_N = 7;

	// result returned for an unknown opcode
	localparam logic [DATA_W-1:0] RES_FILL = 16'hdeae;

	// ========================================
	// micro-op word and pipeline types
	// ========================================

	// register form, three source/destination indices
	typedef struct packed {
		logic [OP_W-1:0]   op;
		logic [REG_AW-1:0] dst;
		logic [REG_AW-1:0] src1;
		logic [REG_AW-1:0] src2;
		logic [UOP_W-16:0] pad;
	} uop_reg_t;

	// immediate form for LDIB, imm lies over src1, src2 and the top of pad
	typedef struct packed {
		logic [OP_W-1:0]   op;
		logic [REG_AW-1:0] dst;
		logic [7:0]        imm;
		logic [UOP_W-18:0] pad;
	} uop_imm_t;

	typedef union packed {
		uop_reg_t rg;
		uop_imm_t im;
	} uop_word_t;

	// operands handed from the issue stage to the ALU stage
	typedef struct packed {
		logic [OP_W-1:0]   op;
		logic [DATA_W-1:0] dst_val;
		logic [DATA_W-1:0] src1_val;
		logic [DATA_W-1:0] src2_val;
		logic [REG_AW-1:0] wr_idx;
		logic              wr_en;
	} opnd_t;

	// register file write port
	typedef struct packed {
		logic              en;
		logic [REG_AW-1:0] idx;
		logic [DATA_W-1:0] data;
	} wb_t;

endpackage

/* uop_alu.sv */
// ========================================
// combinational micro-op ALU, byte ops work on bits 7:0 of each operand
// carry out is taken from bit 8 of the 16-bit result
// unknown opcodes return the filler word and clear the whole status byte
// ========================================

`timescale 1ns/1ns

module uop_alu (
	input  logic [uop_pkg::OP_W-1:0]   op_i,
	input  logic [uop_pkg::DATA_W-1:0] dst_i,
	input  logic [uop_pkg::DATA_W-1:0] src1_i,
	input  logic [uop_pkg::DATA_W-1:0] src2_i,
	input  logic [7:0]                 s_i,
	output logic [uop_pkg::DATA_W-1:0] res_o,
	output logic [7:0]                 s_o
);

	// low bytes of the three operands
	logic [7:0] d8;
	logic [7:0] a8;
	logic [7:0] b8;
	// carry in and the inverted carry used as borrow
	logic       cin;
	logic       bin;
	// flag terms taken from the result byte
	logic       zero8;
	logic       neg8;
	logic       v_adc;
	logic       v_sbc;

	assign d8  = dst_i[7:0];
	assign a8  = src1_i[7:0];
	assign b8  = src2_i[7:0];
	assign cin = s_i[uop_pkg::ST_C];
	// a clear carry means a borrow is pending
	assign bin = ~s_i[uop_pkg::ST_C];

	// ========================================
	// result
	// ========================================

	always_comb
	begin
		case (op_i)
			// immediate arrives in src1, sign-extended to the full word
			uop_pkg::UO_LDIB: res_o = {{8{a8[7]}}, a8};
			// the only full-width operation
			uop_pkg::UO_ADDW: res_o = dst_i + src1_i + src2_i;
			uop_pkg::UO_ADDB: res_o = {8'h00, d8} + {8'h00, a8} + {8'h00, b8};
			uop_pkg::UO_ADCB: res_o = {8'h00, d8} + {8'h00, a8} + {8'h00, b8} + {15'd0, cin};
			uop_pkg::UO_SBCB: res_o = {8'h00, d8} - {8'h00, a8} - {8'h00, b8} - {15'd0, bin};
			// compare runs the same subtraction, the result is only used for flags
			uop_pkg::UO_CMPB: res_o = {8'h00, d8} - {8'h00, a8} - {8'h00, b8} - {15'd0, bin};
			uop_pkg::UO_ANDB: res_o = {8'h00, d8 & a8 & b8};
			uop_pkg::UO_BITB: res_o = {8'h00, d8 & a8 & b8};
			uop_pkg::UO_ORB:  res_o = {8'h00, d8 | a8 | b8};
			uop_pkg::UO_EORB: res_o = {8'h00, d8 ^ a8 ^ b8};
			uop_pkg::UO_MOV:  res_o = {8'h00, b8};
			// shifts park the bit shifted out in bit 8 so the carry rule is shared
			uop_pkg::UO_ASLB: res_o = {7'h00, d8, 1'b0};
			uop_pkg::UO_LSRB: res_o = {7'h00, d8[0], 1'b0, d8[7:1]};
			uop_pkg::UO_ROLB: res_o = {7'h00, d8, cin};
			uop_pkg::UO_RORB: res_o = {7'h00, d8[0], cin, d8[7:1]};
			default:          res_o = uop_pkg::RES_FILL;
		endcase
	end

	assign zero8 = (res_o[7:0] == 8'h00);
	assign neg8  = res_o[7];

	// signed overflow from bit 7 of the operands and of the result
	assign v_adc = (res_o[7] ^ a8[7] ^ b8[7]) & ~(d8[7] ^ a8[7] ^ b8[7]);
	assign v_sbc = ~(res_o[7] ^ a8[7] ^ b8[7]) & (d8[7] ^ a8[7] ^ b8[7]);

	// ========================================
	// status
	// ========================================

	always_comb
	begin
		// bits that an op does not name keep their old value
		s_o = s_i;
		case (op_i)
			uop_pkg::UO_LDIB, uop_pkg::UO_ADDB, uop_pkg::UO_ANDB,
			uop_pkg::UO_BITB, uop_pkg::UO_ORB, uop_pkg::UO_EORB,
			uop_pkg::UO_MOV:
			begin
				s_o[uop_pkg::ST_Z] = zero8;
				s_o[uop_pkg::ST_N] = neg8;
			end
			uop_pkg::UO_ADCB:
			begin
				s_o[uop_pkg::ST_C] = res_o[8];
				s_o[uop_pkg::ST_Z] = zero8;
				s_o[uop_pkg::ST_V] = v_adc;
				s_o[uop_pkg::ST_N] = neg8;
			end
			uop_pkg::UO_SBCB:
			begin
				// carry set means no borrow came out of bit 7
				s_o[uop_pkg::ST_C] = ~res_o[8];
				s_o[uop_pkg::ST_Z] = zero8;
				s_o[uop_pkg::ST_V] = v_sbc;
				s_o[uop_pkg::ST_N] = neg8;
			end
			uop_pkg::UO_CMPB, uop_pkg::UO_ASLB, uop_pkg::UO_LSRB,
			uop_pkg::UO_ROLB, uop_pkg::UO_RORB:
			begin
				s_o[uop_pkg::ST_C] = res_o[8];
				s_o[uop_pkg::ST_Z] = zero8;
				s_o[uop_pkg::ST_N] = neg8;
			end
			// the word add leaves every flag alone
			uop_pkg::UO_ADDW: s_o = s_i;
			uop_pkg::UO_CLC:  s_o[uop_pkg::ST_C] = 1'b0;
			uop_pkg::UO_SEC:  s_o[uop_pkg::ST_C] = 1'b1;
			uop_pkg::UO_CLV:  s_o[uop_pkg::ST_V] = 1'b0;
			uop_pkg::UO_SEI:  s_o[uop_pkg::ST_I] = 1'b1;
			uop_pkg::UO_CLI:  s_o[uop_pkg::ST_I] = 1'b0;
			uop_pkg::UO_SED:  s_o[uop_pkg::ST_D] = 1'b1;
			uop_pkg::UO_CLD:  s_o[uop_pkg::ST_D] = 1'b0;
			uop_pkg::UO_SEB:  s_o[uop_pkg::ST_B] = 1'b1;
			uop_pkg::UO_CLB:  s_o[uop_pkg::ST_B] = 1'b0;
			default:          s_o = 8'h00;
		endcase
	end

endmodule

/* uop_regfile.sv */
// ========================================
// eight 16-bit registers, register 0 reads as zero and ignores writes
// reads are asynchronous, a write lands on the rising edge
// ========================================

`timescale 1ns/1ns

module uop_regfile (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  logic [uop_pkg::REG_AW-1:0] ra0_i,
	input  logic [uop_pkg::REG_AW-1:0] ra1_i,
	input  logic [uop_pkg::REG_AW-1:0] ra2_i,
	output logic [uop_pkg::DATA_W-1:0] rd0_o,
	output logic [uop_pkg::DATA_W-1:0] rd1_o,
	output logic [uop_pkg::DATA_W-1:0] rd2_o,
	input  uop_pkg::wb_t               wb_i
);

	logic [uop_pkg::DATA_W-1:0] regs_q [uop_pkg::NREG];

	// one read port, index 0 is forced to zero
	function automatic logic [uop_pkg::DATA_W-1:0] rd_port(
		input logic [uop_pkg::REG_AW-1:0] ra,
		input logic [uop_pkg::DATA_W-1:0] val
	);
		logic [uop_pkg::DATA_W-1:0] r;
		r = (ra == '0) ? '0 : val;
		return r;
	endfunction

	// ========================================
	// write port
	// ========================================

	// the whole file starts out at zero
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			for (int n = 0; n < uop_pkg::NREG; n++)
				regs_q[n] <= '0;
		end
		else if (wb_i.en && (wb_i.idx != '0))
		begin
			regs_q[wb_i.idx] <= wb_i.data;
		end
	end

	// ========================================
	// read ports
	// ========================================

	// port 0 serves dst, port 1 src1 and port 2 src2
	assign rd0_o = rd_port(ra0_i, regs_q[ra0_i]);
	assign rd1_o = rd_port(ra1_i, regs_q[ra1_i]);
	assign rd2_o = rd_port(ra2_i, regs_q[ra2_i]);

endmodule

/* uop_exec.sv */
// ========================================
// two-stage execute pipeline, fixed latency of two cycles and no stalls
// a micro-op may enter every cycle, the one in the ALU stage is forwarded
// status updates on every valid micro-op, result and status reset to zero
// ========================================

`timescale 1ns/1ns

module uop_exec (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  logic                       uop_valid_i,
	input  uop_pkg::uop_word_t         uop_i,
	output logic [uop_pkg::REG_AW-1:0] ra0_o,
	output logic [uop_pkg::REG_AW-1:0] ra1_o,
	output logic [uop_pkg::REG_AW-1:0] ra2_o,
	input  logic [uop_pkg::DATA_W-1:0] rd0_i,
	input  logic [uop_pkg::DATA_W-1:0] rd1_i,
	input  logic [uop_pkg::DATA_W-1:0] rd2_i,
	output uop_pkg::wb_t               wb_o,
	output logic                       res_valid_o,
	output logic [uop_pkg::DATA_W-1:0] res_o,
	output logic [7:0]                 status_o,
	output logic                       busy_o
);

	uop_pkg::opnd_t             opnd_d;
	uop_pkg::opnd_t             opnd_q;
	logic                       s1_valid_q;
	logic                       s2_valid_q;
	logic [uop_pkg::DATA_W-1:0] alu_res;
	logic [7:0]                 alu_st;
	logic [uop_pkg::DATA_W-1:0] res_q;
	logic [7:0]                 status_q;

	// compare, bit test, flag ops and unknown opcodes leave the registers alone
	function automatic logic op_writes(input logic [uop_pkg::OP_W-1:0] op);
		logic w;
		case (op)
			uop_pkg::UO_LDIB, uop_pkg::UO_ADDW, uop_pkg::UO_ADDB, uop_pkg::UO_ADCB,
			uop_pkg::UO_SBCB, uop_pkg::UO_ANDB, uop_pkg::UO_ORB, uop_pkg::UO_EORB,
			uop_pkg::UO_MOV, uop_pkg::UO_ASLB, uop_pkg::UO_LSRB, uop_pkg::UO_ROLB,
			uop_pkg::UO_RORB: w = 1'b1;
			default:          w = 1'b0;
		endcase
		return w;
	endfunction

	// take the ALU-stage result when it is about to be written to the same index
	function automatic logic [uop_pkg::DATA_W-1:0] fwd(
		input logic [uop_pkg::REG_AW-1:0] ra,
		input logic [uop_pkg::DATA_W-1:0] rd,
		input uop_pkg::wb_t               wb
	);
		logic [uop_pkg::DATA_W-1:0] v;
		v = (wb.en && (wb.idx == ra)) ? wb.data : rd;
		return v;
	endfunction

	// ========================================
	// issue stage
	// ========================================

	assign ra0_o = uop_i.rg.dst;
	assign ra1_o = uop_i.rg.src1;
	assign ra2_o = uop_i.rg.src2;

	always_comb
	begin
		opnd_d.op       = uop_i.rg.op;
		opnd_d.dst_val  = fwd(ra0_o, rd0_i, wb_o);
		opnd_d.src2_val = fwd(ra2_o, rd2_i, wb_o);
		// LDIB reads the same bits as an immediate, the ALU sign-extends it
		if (uop_i.rg.op == uop_pkg::UO_LDIB)
			opnd_d.src1_val = {8'h00, uop_i.im.imm};
		else
			opnd_d.src1_val = fwd(ra1_o, rd1_i, wb_o);
		opnd_d.wr_idx   = uop_i.rg.dst;
		// a write to register 0 would be lost anyway, so it is never issued
		opnd_d.wr_en    = op_writes(uop_i.rg.op) && (uop_i.rg.dst != '0);
	end

	// operand payload, only meaningful while s1_valid_q is set
	always_ff @(posedge clk_i)
	begin
		if (uop_valid_i)
			opnd_q <= opnd_d;
	end

	// ========================================
	// ALU stage
	// ========================================

	uop_alu i_alu (
		.op_i   (opnd_q.op),
		.dst_i  (opnd_q.dst_val),
		.src1_i (opnd_q.src1_val),
		.src2_i (opnd_q.src2_val),
		.s_i    (status_q),
		.res_o  (alu_res),
		.s_o    (alu_st)
	);

	// the register file takes this on the same edge that registers res_q
	assign wb_o.en   = s1_valid_q & opnd_q.wr_en;
	assign wb_o.idx  = opnd_q.wr_idx;
	assign wb_o.data = alu_res;

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			s1_valid_q <= 1'b0;
			s2_valid_q <= 1'b0;
			res_q      <= '0;
			status_q   <= 8'h00;
		end
		else
		begin
			s1_valid_q <= uop_valid_i;
			s2_valid_q <= s1_valid_q;
			if (s1_valid_q)
			begin
				res_q    <= alu_res;
				status_q <= alu_st;
			end
		end
	end

	assign res_valid_o = s2_valid_q;
	assign res_o       = res_q;
	assign status_o    = status_q;
	// the result stage counts as busy until its pulse has been shown
	assign busy_o      = s1_valid_q | s2_valid_q;

endmodule

/* uop_core_top.sv */
// ========================================
// micro-op execution cluster, one micro-op per cycle, no back-pressure
// results appear two cycles after the valid strobe
// ========================================

`timescale 1ns/1ns

module uop_core_top (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  logic                       uop_valid_i,
	input  uop_pkg::uop_word_t         uop_i,
	output logic                       res_valid_o,
	output logic [uop_pkg::DATA_W-1:0] res_o,
	output logic [7:0]                 status_o,
	output logic                       idle_o
);

	// read addresses and data between the pipeline and the register file
	logic [uop_pkg::REG_AW-1:0] ra0;
	logic [uop_pkg::REG_AW-1:0] ra1;
	logic [uop_pkg::REG_AW-1:0] ra2;
	logic [uop_pkg::DATA_W-1:0] rd0;
	logic [uop_pkg::DATA_W-1:0] rd1;
	logic [uop_pkg::DATA_W-1:0] rd2;
	uop_pkg::wb_t               wb;
	logic                       busy;

	uop_regfile i_regfile (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.ra0_i   (ra0),
		.ra1_i   (ra1),
		.ra2_i   (ra2),
		.rd0_o   (rd0),
		.rd1_o   (rd1),
		.rd2_o   (rd2),
		.wb_i    (wb)
	);

	uop_exec i_exec (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.uop_valid_i (uop_valid_i),
		.uop_i       (uop_i),
		.ra0_o       (ra0),
		.ra1_o       (ra1),
		.ra2_o       (ra2),
		.rd0_i       (rd0),
		.rd1_i       (rd1),
		.rd2_i       (rd2),
		.wb_o        (wb),
		.res_valid_o (res_valid_o),
		.res_o       (res_o),
		.status_o    (status_o),
		.busy_o      (busy)
	);

	// idle once both pipeline stages have drained
	assign idle_o = ~busy;

endmodule

/* uop_core_chk.sv */
// ========================================
// timing and reset rules of the cluster
// bound into uop_core_top, watches the internal writeback port
// ========================================

`timescale 1ns/1ns

module uop_core_chk (
	input logic         clk_i,
	input logic         rst_n_i,
	input logic         uop_valid_i,
	input logic         res_valid_i,
	input logic [7:0]   status_i,
	input logic         idle_i,
	input uop_pkg::wb_t wb_i
);

	// fixed latency, the strobe sampled at edge k shows up at edge k+2
	a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		res_valid_i == $past(uop_valid_i, 2))
		else $error("result strobe does not follow the valid strobe by two cycles");

	// outputs stay quiet while reset is held
	a_reset: assert property (@(posedge clk_i)
		!rst_n_i |-> (!res_valid_i && status_i == 8'h00))
		else $error("outputs not cleared during reset");

	// a micro-op in either stage keeps the cluster busy
	a_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		($past(uop_valid_i) || $past(uop_valid_i, 2)) |-> !idle_i)
		else $error("idle raised while a micro-op is in flight");

	a_wb_r0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_i.en |-> (wb_i.idx != '0))
		else $error("writeback targets register 0");

endmodule

/* tb_uop_tasks.svh */
// ========================================
// directed tests and the ALU reference model
// included inside tb_uop_core and uses its signals and model state
// ========================================

`ifndef TB_UOP_TASKS_SVH
`define TB_UOP_TASKS_SVH

function automatic uop_pkg::uop_word_t reg_word(input logic [5:0] op, input logic [2:0] d,
	input logic [2:0] s1, input logic [2:0] s2);
	uop_pkg::uop_word_t w;
	w         = '0;
	w.rg.op   = op;
	w.rg.dst  = d;
	w.rg.src1 = s1;
	w.rg.src2 = s2;
	return w;
endfunction

function automatic uop_pkg::uop_word_t ldib_word(input logic [2:0] d, input logic [7:0] imm);
	uop_pkg::uop_word_t w;
	w        = '0;
	w.im.op  = uop_pkg::UO_LDIB;
	w.im.dst = d;
	w.im.imm = imm;
	return w;
endfunction

// steps one micro-op through the reference rules and updates the model registers and status
task automatic model_step(input uop_pkg::uop_word_t w, output exp_t e);
	logic [5:0]  op;
	logic [15:0] d;
	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] r;
	logic [7:0]  s;
	logic        c;
	logic        wr;
	logic        x;
	op = w.rg.op;
	d  = m_regs[w.rg.dst];
	a  = (op == uop_pkg::UO_LDIB) ? {8'h00, w.im.imm} : m_regs[w.rg.src1];
	b  = m_regs[w.rg.src2];
	s  = m_st;
	c  = s[uop_pkg::ST_C];
	// sign of the two source bytes taken together as one addend
	x  = a[7] ^ b[7];
	// only micro-ops that produce a register value write back
	wr = (op >= uop_pkg::UO_LDIB) && (op <= uop_pkg::UO_RORB) &&
		(op != uop_pkg::UO_CMPB) && (op != uop_pkg::UO_BITB);
	case (op)
		uop_pkg::UO_LDIB: r = {{8{a[7]}}, a[7:0]};
		uop_pkg::UO_ADDW: r = d + a + b;
		uop_pkg::UO_ADDB: r = d[7:0] + a[7:0] + b[7:0];
		uop_pkg::UO_ADCB: r = d[7:0] + a[7:0] + b[7:0] + c;
		uop_pkg::UO_SBCB: r = d[7:0] - a[7:0] - b[7:0] - !c;
		uop_pkg::UO_CMPB: r = d[7:0] - a[7:0] - b[7:0] - !c;
		uop_pkg::UO_ANDB: r = d[7:0] & a[7:0] & b[7:0];
		uop_pkg::UO_BITB: r = d[7:0] & a[7:0] & b[7:0];
		uop_pkg::UO_ORB:  r = d[7:0] | a[7:0] | b[7:0];
		uop_pkg::UO_EORB: r = d[7:0] ^ a[7:0] ^ b[7:0];
		uop_pkg::UO_MOV:  r = b[7:0];
		uop_pkg::UO_ASLB: r = {d[7:0], 1'b0};
		uop_pkg::UO_LSRB: r = {d[0], 1'b0, d[7:1]};
		uop_pkg::UO_ROLB: r = {d[7:0], c};
		uop_pkg::UO_RORB: r = {d[0], c, d[7:1]};
		default:          r = uop_pkg::RES_FILL;
	endcase
	case (op)
		uop_pkg::UO_ADDW: ;
		uop_pkg::UO_CLC: s[uop_pkg::ST_C] = 0;
		uop_pkg::UO_SEC: s[uop_pkg::ST_C] = 1;
		uop_pkg::UO_CLV: s[uop_pkg::ST_V] = 0;
		uop_pkg::UO_SEI: s[uop_pkg::ST_I] = 1;
		uop_pkg::UO_CLI: s[uop_pkg::ST_I] = 0;
		uop_pkg::UO_SED: s[uop_pkg::ST_D] = 1;
		uop_pkg::UO_CLD: s[uop_pkg::ST_D] = 0;
		uop_pkg::UO_SEB: s[uop_pkg::ST_B] = 1;
		uop_pkg::UO_CLB: s[uop_pkg::ST_B] = 0;
		default:
		begin
			if (op == 0 || op > uop_pkg::UO_CLB)
				s = 8'h00;
			else
			begin
				s[uop_pkg::ST_Z] = (r[7:0] == 8'h00);
				s[uop_pkg::ST_N] = r[7];
				// carry comes out of bit 8 and is inverted into a borrow for subtract
				if (op == uop_pkg::UO_ADCB || op == uop_pkg::UO_CMPB || op >= uop_pkg::UO_ASLB)
					s[uop_pkg::ST_C] = r[8];
				if (op == uop_pkg::UO_SBCB)
					s[uop_pkg::ST_C] = !r[8];
				// overflow when the result byte leaves the sign of the destination byte
				if (op == uop_pkg::UO_ADCB)
					s[uop_pkg::ST_V] = (d[7] == x) && (r[7] != d[7]);
				if (op == uop_pkg::UO_SBCB)
					s[uop_pkg::ST_V] = (d[7] != x) && (r[7] != d[7]);
			end
		end
	endcase
	if (wr && w.rg.dst != 0)
		m_regs[w.rg.dst] = r;
	m_st  = s;
	e.res = r;
	e.st  = s;
endtask

// drive one micro-op on the next rising edge and hold valid
task automatic issue(input uop_pkg::uop_word_t w);
	exp_t e;
	model_step(w, e);
	exp_q.push_back(e);
	@(posedge clk_i);
	uop_valid_i <= 1'b1;
	uop_i       <= w;
endtask

// drop valid and wait until every outstanding result has been seen
task automatic drain();
	int n;
	n = 0;
	@(posedge clk_i);
	uop_valid_i <= 1'b0;
	while (exp_q.size() != 0 && n < 8)
	begin
		@(negedge clk_i);
		n++;
	end
	if (exp_q.size() != 0)
	begin
		$display("%s: result strobe missing for %0d micro-ops", cur_test, exp_q.size());
		errors++;
		exp_q.delete();
	end
endtask

task automatic run_one(input uop_pkg::uop_word_t w);
	issue(w);
	drain();
endtask

task automatic set_carry(input logic c);
	run_one(reg_word(c ? uop_pkg::UO_SEC : uop_pkg::UO_CLC, 0, 0, 0));
endtask

task automatic report_test(input int err0);
	$display("test %s finished with %0d errors", cur_test, errors - err0);
endtask

task automatic reset_state();
	int err0;
	err0     = errors;
	cur_test = "reset";
	@(negedge clk_i);
	assert (idle_o === 1'b1 && res_valid_o === 1'b0 && status_o === 8'h00)
	else
	begin
		$display("outputs are not in their reset state after reset");
		errors++;
	end
	// sign extension of a negative immediate sets N and leaves Z clear
	run_one(ldib_word(1, 8'h9c));
	assert (res_o === 16'hff9c)
	else
	begin
		$display("MISMATCH %s res expected %h actual %h", cur_test, 16'hff9c, res_o);
		errors++;
	end
	assert (status_o === 8'h80)
	else
	begin
		$display("MISMATCH %s status expected %h actual %h", cur_test, 8'h80, status_o);
		errors++;
	end
	report_test(err0);
endtask

task automatic arith_random();
	int err0;
	err0     = errors;
	cur_test = "arith";
	for (int i = 0; i < 6; i++)
	begin
		run_one(ldib_word(1, 8'($random(seed))));
		run_one(ldib_word(2, 8'($random(seed))));
		run_one(ldib_word(3, 8'($random(seed))));
		run_one(reg_word(uop_pkg::UO_ADDB, 4, 2, 3));
		set_carry(1'($random(seed)));
		run_one(reg_word(uop_pkg::UO_ADCB, 1, 2, 3));
		set_carry(1'($random(seed)));
		run_one(reg_word(uop_pkg::UO_SBCB, 4, 2, 3));
		run_one(reg_word(uop_pkg::UO_ADDW, 5, 1, 2));
		run_one(reg_word(uop_pkg::UO_ADDW, 6, 5, 5));
	end
	report_test(err0);
endtask

task automatic logic_compare();
	int err0;
	err0     = errors;
	cur_test = "logic";
	run_one(ldib_word(1, 8'($random(seed))));
	run_one(ldib_word(2, 8'($random(seed))));
	run_one(ldib_word(3, 8'($random(seed))));
	run_one(reg_word(uop_pkg::UO_ANDB, 4, 2, 3));
	run_one(reg_word(uop_pkg::UO_ORB, 5, 2, 3));
	run_one(reg_word(uop_pkg::UO_EORB, 6, 2, 3));
	run_one(reg_word(uop_pkg::UO_MOV, 7, 0, 3));
	// BITB only sets flags and the following MOV shows that r1 kept its value
	run_one(reg_word(uop_pkg::UO_BITB, 1, 2, 3));
	run_one(reg_word(uop_pkg::UO_MOV, 7, 0, 1));
	set_carry(1'b1);
	run_one(reg_word(uop_pkg::UO_CMPB, 1, 2, 0));
	run_one(reg_word(uop_pkg::UO_MOV, 7, 0, 1));
	report_test(err0);
endtask

task automatic shift_rotate();
	int err0;
	logic [5:0] ops [4];
	err0     = errors;
	cur_test = "shift";
	ops      = '{uop_pkg::UO_ASLB, uop_pkg::UO_LSRB, uop_pkg::UO_ROLB, uop_pkg::UO_RORB};
	for (int c = 0; c < 2; c++)
	begin
		for (int k = 0; k < 4; k++)
		begin
			run_one(ldib_word(1, 8'($random(seed)) | 8'h81));
			set_carry(c[0]);
			run_one(reg_word(ops[k], 1, 0, 0));
		end
	end
	report_test(err0);
endtask

task automatic flag_ops();
	int err0;
	err0     = errors;
	cur_test = "flags";
	for (logic [5:0] op = uop_pkg::UO_CLC; op <= uop_pkg::UO_CLB; op++)
		run_one(reg_word(op, 0, 0, 0));
	run_one(reg_word(6'h3f, 2, 1, 1));
	report_test(err0);
endtask

task automatic dependent_chain();
	int err0;
	err0     = errors;
	cur_test = "back_to_back";
	// each micro-op reads the register written by the one before it
	issue(ldib_word(1, 8'h35));
	issue(reg_word(uop_pkg::UO_ADDB, 1, 1, 1));
	issue(reg_word(uop_pkg::UO_ADDW, 2, 1, 1));
	issue(reg_word(uop_pkg::UO_ADDB, 3, 2, 1));
	issue(reg_word(uop_pkg::UO_MOV, 4, 0, 3));
	issue(reg_word(uop_pkg::UO_EORB, 5, 4, 3));
	drain();
	@(negedge clk_i);
	assert (idle_o === 1'b1)
	else
	begin
		$display("idle did not return after the last micro-op");
		errors++;
	end
	report_test(err0);
endtask

`endif

/* tb_uop_core.sv */
// ========================================
// directed testbench of the micro-op cluster
// expected values come from a model that is stepped in issue order
// ========================================

`timescale 1ns/1ns

module tb_uop_core;

	localparam int CLK_PERIOD = 100;
	localparam int RST_CYCLES = 10;
	// upper bound of micro-ops issued by the whole sequence
	localparam int MAX_UOPS   = 160;

	typedef struct packed {
		logic [15:0] res;
		logic [7:0]  st;
	} exp_t;

	logic               clk_i;
	logic               rst_n_i;
	logic               uop_valid_i;
	uop_pkg::uop_word_t uop_i;
	logic               res_valid_o;
	logic [15:0]        res_o;
	logic [7:0]         status_o;
	logic               idle_o;

	// model state and bookkeeping
	logic [15:0] m_regs [8];
	logic [7:0]  m_st;
	exp_t        exp_q[$];
	string       cur_test;
	int          errors;
	int          checks;
	int          seed;

	uop_core_top i_dut (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.uop_valid_i (uop_valid_i),
		.uop_i       (uop_i),
		.res_valid_o (res_valid_o),
		.res_o       (res_o),
		.status_o    (status_o),
		.idle_o      (idle_o)
	);

	bind uop_core_top uop_core_chk i_chk (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.uop_valid_i (uop_valid_i),
		.res_valid_i (res_valid_o),
		.status_i    (status_o),
		.idle_i      (idle_o),
		.wb_i        (wb)
	);

	`include "tb_uop_tasks.svh"

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	// every result pulse is matched against the oldest expected entry
	always @(negedge clk_i)
	begin
		exp_t e;
		if (rst_n_i && res_valid_o)
		begin
			if (exp_q.size() == 0)
			begin
				$display("%s: result strobe seen with no micro-op outstanding", cur_test);
				errors++;
			end
			else
			begin
				e = exp_q.pop_front();
				checks++;
				assert (res_o == e.res)
				else
				begin
					$display("MISMATCH %s res expected %h actual %h", cur_test, e.res, res_o);
					errors++;
				end
				assert (status_o == e.st)
				else
				begin
					$display("MISMATCH %s status expected %h actual %h", cur_test, e.st,
						status_o);
					errors++;
				end
			end
		end
	end

	// watchdog sized from the micro-op budget
	initial
	begin
		#((RST_CYCLES + MAX_UOPS * 4) * CLK_PERIOD);
		$display("watchdog expired before the test sequence finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin
		clk_i       = 1'b0;
		rst_n_i     = 1'b0;
		uop_valid_i = 1'b0;
		uop_i       = '0;
		m_st        = 8'h00;
		errors      = 0;
		checks      = 0;
		seed        = 32'h491c_47e3;
		cur_test    = "reset";
		for (int n = 0; n < 8; n++)
			m_regs[n] = '0;
		repeat (RST_CYCLES) @(posedge clk_i);
		rst_n_i <= 1'b1;
		reset_state();
		arith_random();
		logic_compare();
		shift_rotate();
		flag_ops();
		dependent_chain();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* all.f */
+incdir+.
uop_pkg.sv
uop_alu.sv
uop_regfile.sv
uop_exec.sv
uop_core_top.sv
uop_core_chk.sv
tb_uop_core.sv

/* Makefile */
# Verilator build for the micro-op cluster testbench

TOP := tb_uop_core
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf obj_dir $(LOG)
